// ==== include/mult_cfg.svh ====
////////////////////
// Widths of the RV32M multiplier unit
// MULT_HALF must stay at half of MULT_XLEN, the core splits operands in two halves
////////////////////

`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

////////////////////
// Data path widths
////////////////////

// Operand and result word
`define MULT_XLEN 32

// One operand half, without the extension bit
`define MULT_HALF 16

// The four partial products together cover
// MULT_XLEN by MULT_XLEN bits, so the high word
// of the full product comes out of the accumulator
// after the last half-product step

`endif

// ==== rtl/mult_pkg.sv ====
////////////////////
// Shared types of the multiplier unit
// Widths come from the cfg header
////////////////////

`default_nettype none

`include "mult_cfg.svh"

package mult_pkg;

  ////////////////////
  // Data types
  ////////////////////

  // Operand or result word
  typedef logic [`MULT_XLEN-1:0] word_t;

  // Operand half plus one extension bit
  // High halves take the sign bit or zero, low halves always zero
  typedef logic signed [`MULT_HALF:0] half_t;

  // Accumulator for shifted partial products and carry
  typedef logic signed [`MULT_XLEN+1:0] acc_t;

  ////////////////////
  // Operators and states
  ////////////////////

  // RV32M multiply flavors
  typedef enum logic [1:0] {
    MUL_M32 = 2'b00,
    MUL_H   = 2'b01,
    MUL_HSU = 2'b10,
    MUL_HU  = 2'b11
  } mul_op_e;

  // Core FSM, one state per half product
  typedef enum logic [2:0] {
    IDLE,
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

endpackage

`default_nettype wire

// ==== rtl/mult_issue.sv ====
////////////////////
// Input register of the multiplier, holds one accepted operation
// Sender keeps operator and operands stable while valid_i waits for ready_o
////////////////////

`timescale 1ns/10ps
`default_nettype none

module mult_issue
  import mult_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       arst_n_i,
  // Upstream side
  input  wire logic       valid_i,
  output logic            ready_o,
  input  mul_op_e         operator_i,
  input  word_t           op_a_i,
  input  word_t           op_b_i,
  // Towards the core
  output logic            iss_valid_o,
  input  wire logic       iss_ready_i,
  output mul_op_e         iss_op_o,
  output word_t           iss_a_o,
  output word_t           iss_b_o,
  output logic [1:0]      iss_sign_o
);

  logic       full_q;
  logic       accept;
  logic [1:0] sign_d;

  // Room when empty or when the core drains the entry now
  assign ready_o = !full_q || iss_ready_i;
  assign accept  = valid_i && ready_o;

  // Operand signedness, bit 0 for a and bit 1 for b
  // MUL_M32 ignores it, the lower word is the same either way
  always_comb begin
    case (operator_i)
      MUL_H:   sign_d = 2'b11;
      MUL_HSU: sign_d = 2'b01;
      default: sign_d = 2'b00;
    endcase
  end

  // Occupancy flag
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (iss_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Operation payload
  always_ff @(posedge clk) begin
    if (accept) begin
      iss_op_o   <= operator_i;
      iss_a_o    <= op_a_i;
      iss_b_o    <= op_b_i;
      iss_sign_o <= sign_d;
    end
  end

  assign iss_valid_o = full_q;

  // Stalled sender must not change the pending operation
  a_input_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
    (valid_i && !ready_o) |=>
      ($stable(operator_i) && $stable(op_a_i) && $stable(op_b_i)))
    else $error("operator or operands changed while waiting for ready_o");

endmodule

`default_nettype wire

// ==== rtl/mult_core.sv ====
////////////////////
// Multiplier core, MUL in one cycle, MULH flavors in four 17x17 steps
// Takes a new operation only in IDLE, holds a result until res_ready_i
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_core
  import mult_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  arst_n_i,
  // From the issue register
  input  wire logic  iss_valid_i,
  output logic       iss_ready_o,
  input  mul_op_e    iss_op_i,
  input  word_t      iss_a_i,
  input  word_t      iss_b_i,
  input  wire logic [1:0] iss_sign_i,
  // To the result buffer
  output logic       res_valid_o,
  input  wire logic  res_ready_i,
  output word_t      res_data_o
);

  mult_state_e state_q;
  mult_state_e state_d;
  acc_t        acc_q;
  acc_t        acc_d;
  acc_t        pp;
  acc_t        sum;
  half_t       a_lo;
  half_t       a_hi;
  half_t       b_lo;
  half_t       b_hi;
  half_t       mul_a;
  half_t       mul_b;
  word_t       a_q;
  word_t       b_q;
  word_t       mul_res_q;
  logic [1:0]  sign_q;
  logic        mul_valid_q;
  logic        take;

  // New work only in IDLE with no MUL result left behind
  assign iss_ready_o = (state_q == IDLE) && (!mul_valid_q || res_ready_i);
  assign take        = iss_valid_i && iss_ready_o;

  ////////////////////
  // Half-product datapath
  ////////////////////

  // Low halves zero extended, high halves follow the signedness
  assign a_lo = {1'b0, a_q[`MULT_HALF-1:0]};
  assign b_lo = {1'b0, b_q[`MULT_HALF-1:0]};
  assign a_hi = {sign_q[0] & a_q[`MULT_XLEN-1], a_q[`MULT_XLEN-1:`MULT_HALF]};
  assign b_hi = {sign_q[1] & b_q[`MULT_XLEN-1], b_q[`MULT_XLEN-1:`MULT_HALF]};

  // Pick the halves for this step
  always_comb begin
    case (state_q)
      ALBH: begin
        mul_a = a_lo;
        mul_b = b_hi;
      end
      AHBL: begin
        mul_a = a_hi;
        mul_b = b_lo;
      end
      AHBH: begin
        mul_a = a_hi;
        mul_b = b_hi;
      end
      default: begin
        mul_a = a_lo;
        mul_b = b_lo;
      end
    endcase
  end

  // One signed 17x17 product per cycle, added to the accumulator
  assign pp  = mul_a * mul_b;
  assign sum = acc_q + pp;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    acc_d   = acc_q;
    case (state_q)
      IDLE: begin
        if (take && (iss_op_i != MUL_M32)) begin
          state_d = ALBL;
        end
      end
      // Drop the low 16 bits, they never reach the high word
      ALBL: begin
        acc_d   = sum >>> `MULT_HALF;
        state_d = ALBH;
      end
      // Cross term at the same weight, no shift
      ALBH: begin
        acc_d   = sum;
        state_d = AHBL;
      end
      AHBL: begin
        acc_d   = sum >>> `MULT_HALF;
        state_d = AHBH;
      end
      // Result is on sum, hold until the buffer takes it
      AHBH: begin
        if (res_ready_i) begin
          acc_d   = '0;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      acc_q       <= '0;
      mul_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      acc_q   <= acc_d;
      if (take && (iss_op_i == MUL_M32)) begin
        mul_valid_q <= 1'b1;
      end else if (res_ready_i) begin
        mul_valid_q <= 1'b0;
      end
    end
  end

  // Operands and the lower product word
  always_ff @(posedge clk) begin
    if (take) begin
      a_q       <= iss_a_i;
      b_q       <= iss_b_i;
      sign_q    <= iss_sign_i;
      mul_res_q <= iss_a_i * iss_b_i;
    end
  end

  // MUL result and AHBH never overlap
  assign res_valid_o = mul_valid_q || (state_q == AHBH);
  assign res_data_o  = (state_q == AHBH) ? sum[`MULT_XLEN-1:0] : mul_res_q;

  // Previous MULH must have cleared the accumulator on its way out
  a_acc_zero_albl : assert property (@(posedge clk) disable iff (!arst_n_i)
    (state_q == ALBL) |-> (acc_q == '0))
    else $error("accumulator not zero at start of MULH");

  a_acc_zero_mul : assert property (@(posedge clk) disable iff (!arst_n_i)
    mul_valid_q |-> (acc_q == '0))
    else $error("accumulator not zero during MUL");

endmodule

`default_nettype wire

// ==== rtl/mult_result.sv ====
////////////////////
// One-entry result buffer between core and downstream stage
// result_o holds while result_valid_o waits for result_ready_i
////////////////////

`timescale 1ns/10ps
`default_nettype none

module mult_result
  import mult_pkg::*;
(
  input  wire logic clk,
  input  wire logic arst_n_i,
  // From the core
  input  wire logic res_valid_i,
  output logic      res_ready_o,
  input  word_t     res_data_i,
  // Downstream side
  output logic      result_valid_o,
  output word_t     result_o,
  input  wire logic result_ready_i
);

  logic  full_q;
  word_t data_q;
  logic  load;

  // Accept when empty or when the entry leaves this cycle
  assign res_ready_o = !full_q || result_ready_i;
  assign load        = res_valid_i && res_ready_o;

  // Full flag
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (result_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Result word
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= res_data_i;
    end
  end

  assign result_valid_o = full_q;
  assign result_o       = data_q;

  // Stalled result stays put and stays valid
  a_result_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
    (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o)))
    else $error("result changed under back-pressure");

endmodule

`default_nettype wire

// ==== rtl/mult_top.sv ====
////////////////////
// RV32M multiplier unit, issue register, core and result buffer
// Up to three operations in flight, results leave in acceptance order
////////////////////

`timescale 1ns/10ps
`default_nettype none

module mult_top
  import mult_pkg::*;
(
  input  wire logic clk,
  input  wire logic arst_n_i,
  // Operation input
  input  wire logic valid_i,
  output logic      ready_o,
  input  mul_op_e   operator_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  // Result output
  output logic      result_valid_o,
  output word_t     result_o,
  input  wire logic result_ready_i
);

  ////////////////////
  // Internal links
  ////////////////////

  // Issue to core
  logic       iss_valid;
  logic       iss_ready;
  mul_op_e    iss_op;
  word_t      iss_a;
  word_t      iss_b;
  logic [1:0] iss_sign;

  // Core to result buffer
  logic       res_valid;
  logic       res_ready;
  word_t      res_data;

  // Input register
  mult_issue issue_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .operator_i  (operator_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .iss_valid_o (iss_valid),
    .iss_ready_i (iss_ready),
    .iss_op_o    (iss_op),
    .iss_a_o     (iss_a),
    .iss_b_o     (iss_b),
    .iss_sign_o  (iss_sign)
  );

  // Multiply FSM and datapath
  mult_core core_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .iss_valid_i (iss_valid),
    .iss_ready_o (iss_ready),
    .iss_op_i    (iss_op),
    .iss_a_i     (iss_a),
    .iss_b_i     (iss_b),
    .iss_sign_i  (iss_sign),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_data_o  (res_data)
  );

  // Output buffer
  mult_result result_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .res_valid_i    (res_valid),
    .res_ready_o    (res_ready),
    .res_data_i     (res_data),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

// ==== sim/mult_checker.sv ====
////////////////////
// Scoreboard for the multiplier ports, expected words in acceptance order
// Also checks the reset state and result stability under back-pressure
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_checker
  import mult_pkg::*;
(
  input  wire logic clk,
  input  wire logic arst_n_i,
  // Operation side of the DUT
  input  wire logic valid_i,
  input  wire logic ready_i,
  input  mul_op_e   op_i,
  input  word_t     a_i,
  input  word_t     b_i,
  // Result side of the DUT
  input  wire logic result_valid_i,
  input  word_t     result_i,
  input  wire logic result_ready_i,
  // Counters for the closing report
  output int        error_count_o,
  output int        result_count_o,
  output int        pending_o
);

  word_t   exp_q[$];
  mul_op_e op_q[$];
  word_t   a_q[$];
  word_t   b_q[$];
  int      errors      = 0;
  int      results     = 0;
  logic    seen_accept = 1'b0;
  logic    hold_q      = 1'b0;
  word_t   held_q      = '0;

  // Expected word from the 64-bit product of the extended operands
  function automatic word_t expected_result(input mul_op_e op, input word_t a, input word_t b);
    logic [2*`MULT_XLEN-1:0] ext_a;
    logic [2*`MULT_XLEN-1:0] ext_b;
    logic [2*`MULT_XLEN-1:0] prod;
    ext_a = {{`MULT_XLEN{1'b0}}, a};
    ext_b = {{`MULT_XLEN{1'b0}}, b};
    // a signed for MULH and MULHSU, b signed only for MULH
    if ((op == MUL_H) || (op == MUL_HSU)) begin
      ext_a = {{`MULT_XLEN{a[`MULT_XLEN-1]}}, a};
    end
    if (op == MUL_H) begin
      ext_b = {{`MULT_XLEN{b[`MULT_XLEN-1]}}, b};
    end
    prod = ext_a * ext_b;
    if (op == MUL_M32) begin
      return prod[`MULT_XLEN-1:0];
    end else begin
      return prod[2*`MULT_XLEN-1:`MULT_XLEN];
    end
  endfunction

  always @(posedge clk) begin
    word_t   exp_w;
    mul_op_e exp_op;
    word_t   exp_a;
    word_t   exp_b;
    if (arst_n_i) begin
      // Reset state holds until the first acceptance
      if (!seen_accept && (!ready_i || result_valid_i)) begin
        $display("Error %0t ns: after reset ready_o was %0b and result_valid_o was %0b",
                 $time, ready_i, result_valid_i);
        errors++;
      end
      // Stalled result must stay valid and unchanged
      if (hold_q && (!result_valid_i || (result_i !== held_q))) begin
        $display("Error %0t ns: stalled result changed from %h to %h (valid %0b)",
                 $time, held_q, result_i, result_valid_i);
        errors++;
      end
      hold_q = result_valid_i && !result_ready_i;
      held_q = result_i;
      // Result transfer, pop the oldest expectation
      if (result_valid_i && result_ready_i) begin
        results++;
        if (exp_q.size() == 0) begin
          $display("A result %h came out with no operation outstanding at %0t ns",
                   result_i, $time);
          errors++;
        end else begin
          exp_w  = exp_q.pop_front();
          exp_op = op_q.pop_front();
          exp_a  = a_q.pop_front();
          exp_b  = b_q.pop_front();
          if (result_i !== exp_w) begin
            $display("Error %0t ns: %s %h x %h gave %h, expected %h",
                     $time, exp_op.name(), exp_a, exp_b, result_i, exp_w);
            errors++;
          end
        end
      end
      // Acceptance, queue its expected word
      if (valid_i && ready_i) begin
        exp_q.push_back(expected_result(op_i, a_i, b_i));
        op_q.push_back(op_i);
        a_q.push_back(a_i);
        b_q.push_back(b_i);
        seen_accept = 1'b1;
      end
    end
    error_count_o  <= errors;
    result_count_o <= results;
    pending_o      <= exp_q.size();
  end

endmodule

`default_nettype wire

// ==== sim/mult_tb.sv ====
////////////////////
// Testbench for the RV32M multiplier unit, random and corner operations
// Results are judged by the checker module, the run stops on a cycle limit
////////////////////

`timescale 1ns/10ps
`default_nettype none

module mult_tb
  import mult_pkg::*;
();

  localparam int          N_OPS        = 400;
  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 10;
  localparam int          MAX_CYCLES   = N_OPS * 12 + 100;
  localparam logic [31:0] SEED         = 32'hb5a33985;

  logic        clk;
  logic        arst_n_i;
  logic        valid_i;
  logic        ready_o;
  mul_op_e     operator_i;
  word_t       op_a_i;
  word_t       op_b_i;
  logic        result_valid_o;
  word_t       result_o;
  logic        result_ready_i;

  int          error_count;
  int          result_count;
  int          pending;
  int          sent;
  int          cycles;
  int          stall;
  logic [31:0] stim_rng;
  logic [31:0] sink_rng;

  ////////////////////
  // Helpers
  ////////////////////

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Corner values now and then, else the random word itself
  function automatic word_t pick_operand(input logic [31:0] r);
    case (r[2:0])
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return 32'h8000_0000;
      default: return r;
    endcase
  endfunction

  // Present one operation and hold it until ready_o takes it
  task automatic send_op(input mul_op_e op, input word_t a, input word_t b);
    valid_i    <= 1'b1;
    operator_i <= op;
    op_a_i     <= a;
    op_b_i     <= b;
    do @(posedge clk); while (!ready_o);
    sent++;
  endtask

  // Gap with valid_i low
  task automatic idle_cycles(input int n);
    valid_i <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  ////////////////////
  // DUT and checker
  ////////////////////

  mult_top dut_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .operator_i     (operator_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

  mult_checker checker_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .valid_i        (valid_i),
    .ready_i        (ready_o),
    .op_i           (operator_i),
    .a_i            (op_a_i),
    .b_i            (op_b_i),
    .result_valid_i (result_valid_o),
    .result_i       (result_o),
    .result_ready_i (result_ready_i),
    .error_count_o  (error_count),
    .result_count_o (result_count),
    .pending_o      (pending)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Operation source
  ////////////////////

  initial begin
    arst_n_i       = 1'b0;
    valid_i        = 1'b0;
    operator_i     = MUL_M32;
    op_a_i         = '0;
    op_b_i         = '0;
    result_ready_i = 1'b0;
    sent           = 0;
    stim_rng       = SEED;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n_i <= 1'b1;
    // A few idle edges so the checker sees the reset state
    repeat (2) @(posedge clk);
    // Corners for every flavor, back to back
    for (int k = 0; k < 4; k++) begin
      send_op(mul_op_e'(k), 32'h8000_0000, 32'h8000_0000);
      send_op(mul_op_e'(k), '1, '1);
    end
    while (sent < N_OPS) begin
      stim_rng = xorshift(stim_rng);
      // Most operations follow the previous one directly
      if (!stim_rng[31] && (stim_rng[30:29] != 2'd0)) begin
        idle_cycles(stim_rng[30:29]);
      end
      stim_rng = xorshift(stim_rng);
      send_op(mul_op_e'(stim_rng[1:0]), pick_operand(stim_rng),
              pick_operand(xorshift(stim_rng)));
    end
    valid_i <= 1'b0;
    // Drain the pipeline, then watch a little longer for extra results
    @(posedge clk);
    while (pending != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    $display("Operations: %0d, results: %0d, pending: %0d, errors: %0d",
             sent, result_count, pending, error_count);
    if ((error_count == 0) && (result_count == sent) && (pending == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  ////////////////////
  // Downstream ready
  ////////////////////

  initial begin
    sink_rng = SEED ^ 32'h9e37_79b9;
    stall    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    // Long stall first, fills all three stages
    repeat (40) @(posedge clk);
    forever begin
      @(posedge clk);
      sink_rng = xorshift(sink_rng);
      if (stall > 0) begin
        result_ready_i <= 1'b0;
        stall--;
      end else if (sink_rng[7:0] == 8'd0) begin
        result_ready_i <= 1'b0;
        stall = 20 + sink_rng[12:8];
      end else begin
        result_ready_i <= (sink_rng[9:8] != 2'd0);
      end
    end
  end

  // Cycle limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Operations: %0d, results: %0d, pending: %0d, errors: %0d",
             sent, result_count, pending, error_count);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
rtl/mult_pkg.sv
rtl/mult_issue.sv
rtl/mult_core.sv
rtl/mult_result.sv
rtl/mult_top.sv
sim/mult_checker.sv
sim/mult_tb.sv

// ==== Bender.yml ====
package:
  name: mult

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mult_pkg.sv
      - rtl/mult_issue.sv
      - rtl/mult_core.sv
      - rtl/mult_result.sv
      - rtl/mult_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/mult_checker.sv
      - sim/mult_tb.sv
